// ==== Bender.yml ====
package:
  name: arm_frontend

sources:
  - rtl/arm_pkg.sv
  - rtl/instruction_memory.sv
  - rtl/if_stage.sv
  - rtl/control_unit.sv
  - rtl/register_file.sv
  - rtl/id_stage.sv
  - rtl/arm_frontend.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_arm_frontend.sv

// ==== arm_frontend.f ====
+incdir+test
rtl/arm_pkg.sv
rtl/instruction_memory.sv
rtl/if_stage.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/id_stage.sv
rtl/arm_frontend.sv
test/tb_arm_frontend.sv

// ==== rtl/arm_frontend.sv ====
`timescale 1ns/1ps

module arm_frontend import arm_pkg::*; (
	input  logic                            clk,
	input  logic                            rst,
	// Instruction memory load
	input  logic                            imem_wr_en,
	input  logic [imem_address_len-1:0]     imem_wr_addr,
	input  logic [instruction_len-1:0]      imem_wr_data,
	// Hazard and branch feedback
	input  logic                            freeze,
	input  logic                            flush,
	input  logic                            branch_taken,
	input  logic [address_len-1:0]          branch_addr,
	input  logic [3:0]                      status,
	// Write-back
	input  logic                            wb_en,
	input  logic [reg_address_len-1:0]      wb_address,
	input  logic [register_len-1:0]         wb_data,
	// Toward execute
	output logic [address_len-1:0]          pc,
	output logic                            mem_read,
	output logic                            mem_write,
	output logic                            wb_enable,
	output logic                            immediate,
	output logic                            branch,
	output logic                            status_write,
	output logic [execute_command_len-1:0]  execute_command,
	output logic [register_len-1:0]         reg1,
	output logic [register_len-1:0]         reg2,
	output logic [reg_address_len-1:0]      dest_reg,
	output logic [signed_immediate_len-1:0] signed_immediate,
	output logic [shift_operand_len-1:0]    shift_operand
);

	logic [imem_address_len-1:0] imem_addr;
	logic [instruction_len-1:0]  imem_data;
	// IF/ID register contents
	logic [address_len-1:0]      if_pc;
	logic [instruction_len-1:0]  if_instruction;

	instruction_memory u_instruction_memory (
		.clk     (clk),
		.wr_en   (imem_wr_en),
		.wr_addr (imem_wr_addr),
		.wr_data (imem_wr_data),
		.rd_addr (imem_addr),
		.rd_data (imem_data)
	);

	if_stage u_if_stage (
		.clk          (clk),
		.rst          (rst),
		.freeze       (freeze),
		.flush        (flush),
		.branch_taken (branch_taken),
		.branch_addr  (branch_addr),
		.imem_addr    (imem_addr),
		.imem_data    (imem_data),
		.pc           (if_pc),
		.instruction  (if_instruction)
	);

	id_stage u_id_stage (
		.clk              (clk),
		.rst              (rst),
		.freeze           (freeze),
		.flush            (flush),
		.pc_in            (if_pc),
		.instruction_in   (if_instruction),
		.status           (status),
		.wb_en            (wb_en),
		.wb_address       (wb_address),
		.wb_data          (wb_data),
		.pc               (pc),
		.mem_read         (mem_read),
		.mem_write        (mem_write),
		.wb_enable        (wb_enable),
		.immediate        (immediate),
		.branch           (branch),
		.status_write     (status_write),
		.execute_command  (execute_command),
		.reg1             (reg1),
		.reg2             (reg2),
		.dest_reg         (dest_reg),
		.signed_immediate (signed_immediate),
		.shift_operand    (shift_operand)
	);

endmodule

// ==== rtl/arm_pkg.sv ====
package arm_pkg;

	// Datapath widths
	localparam int address_len          = 32;
	localparam int instruction_len      = 32;
	localparam int register_len         = 32;
	localparam int reg_address_len      = 4;
	localparam int execute_command_len  = 4;
	localparam int signed_immediate_len = 24;
	localparam int shift_operand_len    = 12;

	// r0 to r14 only, r15 never stored
	localparam int reg_count = 15;

	// Instruction store
	localparam int imem_words       = 64;
	localparam int imem_address_len = 6;

	// Low bit of each instruction field
	localparam int cond_pos     = 28;
	localparam int mode_pos     = 26;
	localparam int imm_pos      = 25;
	localparam int opcode_pos   = 21;
	localparam int s_bit_pos    = 20;
	localparam int rn_pos       = 16;
	localparam int rd_pos       = 12;
	localparam int shift_pos    = 0;
	localparam int simm_pos     = 0;
	localparam int rm_pos       = 0;

	// Instruction classes
	localparam logic [1:0] mode_dp     = 2'b00;
	localparam logic [1:0] mode_mem    = 2'b01;
	localparam logic [1:0] mode_branch = 2'b10;

	// Data processing opcodes
	localparam logic [3:0] op_and = 4'b0000;
	localparam logic [3:0] op_eor = 4'b0001;
	localparam logic [3:0] op_sub = 4'b0010;
	localparam logic [3:0] op_add = 4'b0100;
	localparam logic [3:0] op_adc = 4'b0101;
	localparam logic [3:0] op_sbc = 4'b0110;
	localparam logic [3:0] op_tst = 4'b1000;
	localparam logic [3:0] op_cmp = 4'b1010;
	localparam logic [3:0] op_orr = 4'b1100;
	localparam logic [3:0] op_mov = 4'b1101;
	localparam logic [3:0] op_mvn = 4'b1111;

	// ALU commands for the execute stage
	localparam logic [3:0] exec_mov = 4'b0001;
	localparam logic [3:0] exec_add = 4'b0010;
	localparam logic [3:0] exec_adc = 4'b0011;
	localparam logic [3:0] exec_sub = 4'b0100;
	localparam logic [3:0] exec_sbc = 4'b0101;
	localparam logic [3:0] exec_and = 4'b0110;
	localparam logic [3:0] exec_orr = 4'b0111;
	localparam logic [3:0] exec_eor = 4'b1000;
	localparam logic [3:0] exec_mvn = 4'b1001;

	// Condition field values
	localparam logic [3:0] cond_eq = 4'b0000;
	localparam logic [3:0] cond_ne = 4'b0001;
	localparam logic [3:0] cond_cs = 4'b0010;
	localparam logic [3:0] cond_cc = 4'b0011;
	localparam logic [3:0] cond_mi = 4'b0100;
	localparam logic [3:0] cond_pl = 4'b0101;
	localparam logic [3:0] cond_vs = 4'b0110;
	localparam logic [3:0] cond_vc = 4'b0111;
	localparam logic [3:0] cond_hi = 4'b1000;
	localparam logic [3:0] cond_ls = 4'b1001;
	localparam logic [3:0] cond_ge = 4'b1010;
	localparam logic [3:0] cond_lt = 4'b1011;
	localparam logic [3:0] cond_gt = 4'b1100;
	localparam logic [3:0] cond_le = 4'b1101;
	localparam logic [3:0] cond_al = 4'b1110;
	localparam logic [3:0] cond_nv = 4'b1111;

	// Bit index of each status flag
	localparam int flag_n = 3;
	localparam int flag_z = 2;
	localparam int flag_c = 1;
	localparam int flag_v = 0;

endpackage

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit import arm_pkg::*; (
	input  logic [1:0]                     mode,
	input  logic [3:0]                     opcode,
	input  logic                           s_bit,
	input  logic                           immediate,
	input  logic [3:0]                     cond,
	input  logic [3:0]                     status,
	output logic [execute_command_len-1:0] execute_command,
	output logic                           mem_read,
	output logic                           mem_write,
	output logic                           wb_enable,
	output logic                           branch,
	output logic                           status_write
);

	logic n, z, c, v;
	logic cond_pass;

	assign n = status[flag_n];
	assign z = status[flag_z];
	assign c = status[flag_c];
	assign v = status[flag_v];

	// ARM condition check
	always_comb begin
		case (cond)
			cond_eq: cond_pass = z;
			cond_ne: cond_pass = !z;
			cond_cs: cond_pass = c;
			cond_cc: cond_pass = !c;
			cond_mi: cond_pass = n;
			cond_pl: cond_pass = !n;
			cond_vs: cond_pass = v;
			cond_vc: cond_pass = !v;
			cond_hi: cond_pass = c && !z;
			cond_ls: cond_pass = !c || z;
			cond_ge: cond_pass = (n == v);
			cond_lt: cond_pass = (n != v);
			cond_gt: cond_pass = !z && (n == v);
			cond_le: cond_pass = z || (n != v);
			cond_al: cond_pass = 1'b1;
			// NV, never executes
			default: cond_pass = 1'b0;
		endcase
	end

	// Control decode
	always_comb begin
		execute_command = '0;
		mem_read        = 1'b0;
		mem_write       = 1'b0;
		wb_enable       = 1'b0;
		branch          = 1'b0;
		status_write    = 1'b0;
		case (mode)
			mode_dp: begin
				status_write = s_bit;
				// Compare and test only set flags
				wb_enable = (opcode != op_cmp) && (opcode != op_tst);
				case (opcode)
					op_mov:         execute_command = exec_mov;
					op_mvn:         execute_command = exec_mvn;
					op_add:         execute_command = exec_add;
					op_adc:         execute_command = exec_adc;
					op_sub, op_cmp: execute_command = exec_sub;
					op_sbc:         execute_command = exec_sbc;
					op_and, op_tst: execute_command = exec_and;
					op_orr:         execute_command = exec_orr;
					op_eor:         execute_command = exec_eor;
					default:        execute_command = '0;
				endcase
			end
			mode_mem: begin
				// Address is base plus offset
				execute_command = exec_add;
				if (s_bit) begin
					mem_read  = 1'b1;
					wb_enable = 1'b1;
				end else begin
					mem_write = 1'b1;
				end
			end
			// B is 101 in bits 27 to 25, 100 is block transfer
			mode_branch: branch = immediate;
			default: ;
		endcase
		// Kill the instruction when its condition fails
		if (!cond_pass) begin
			execute_command = '0;
			mem_read        = 1'b0;
			mem_write       = 1'b0;
			wb_enable       = 1'b0;
			branch          = 1'b0;
			status_write    = 1'b0;
		end
	end

endmodule

// ==== rtl/id_stage.sv ====
`timescale 1ns/1ps

module id_stage import arm_pkg::*; (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            freeze,
	input  logic                            flush,
	input  logic [address_len-1:0]          pc_in,
	input  logic [instruction_len-1:0]      instruction_in,
	input  logic [3:0]                      status,
	// Register write-back
	input  logic                            wb_en,
	input  logic [reg_address_len-1:0]      wb_address,
	input  logic [register_len-1:0]         wb_data,
	// ID/EX register
	output logic [address_len-1:0]          pc,
	output logic                            mem_read,
	output logic                            mem_write,
	output logic                            wb_enable,
	output logic                            immediate,
	output logic                            branch,
	output logic                            status_write,
	output logic [execute_command_len-1:0]  execute_command,
	output logic [register_len-1:0]         reg1,
	output logic [register_len-1:0]         reg2,
	output logic [reg_address_len-1:0]      dest_reg,
	output logic [signed_immediate_len-1:0] signed_immediate,
	output logic [shift_operand_len-1:0]    shift_operand
);

	logic [3:0]                     cond;
	logic [1:0]                     mode;
	logic [3:0]                     opcode;
	logic                           s_bit;
	logic                           imm_bit;
	logic [reg_address_len-1:0]     rn;
	logic [reg_address_len-1:0]     rd;
	logic [reg_address_len-1:0]     rm;
	logic [reg_address_len-1:0]     src2;
	logic                           kill;
	logic [execute_command_len-1:0] cu_execute_command;
	logic                           cu_mem_read;
	logic                           cu_mem_write;
	logic                           cu_wb_enable;
	logic                           cu_branch;
	logic                           cu_status_write;
	logic [register_len-1:0]        rf_reg1;
	logic [register_len-1:0]        rf_reg2;

	// Field split
	assign cond    = instruction_in[cond_pos +: 4];
	assign mode    = instruction_in[mode_pos +: 2];
	assign imm_bit = instruction_in[imm_pos];
	assign opcode  = instruction_in[opcode_pos +: 4];
	assign s_bit   = instruction_in[s_bit_pos];
	assign rn      = instruction_in[rn_pos +: reg_address_len];
	assign rd      = instruction_in[rd_pos +: reg_address_len];
	assign rm      = instruction_in[rm_pos +: reg_address_len];

	// A store reads its data from Rd
	assign src2 = (mode == mode_mem && !s_bit) ? rd : rm;

	// Freeze or an empty slot leaves no controls behind
	assign kill = freeze || (instruction_in == '0);

	control_unit u_control_unit (
		.mode            (mode),
		.opcode          (opcode),
		.s_bit           (s_bit),
		.immediate       (imm_bit),
		.cond            (cond),
		.status          (status),
		.execute_command (cu_execute_command),
		.mem_read        (cu_mem_read),
		.mem_write       (cu_mem_write),
		.wb_enable       (cu_wb_enable),
		.branch          (cu_branch),
		.status_write    (cu_status_write)
	);

	register_file u_register_file (
		.clk        (clk),
		.rst        (rst),
		.src1       (rn),
		.src2       (src2),
		.reg1       (rf_reg1),
		.reg2       (rf_reg2),
		.wb_en      (wb_en),
		.wb_address (wb_address),
		.wb_data    (wb_data)
	);

	// ID/EX register
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			pc               <= '0;
			immediate        <= 1'b0;
			reg1             <= '0;
			reg2             <= '0;
			dest_reg         <= '0;
			signed_immediate <= '0;
			shift_operand    <= '0;
			execute_command  <= '0;
			mem_read         <= 1'b0;
			mem_write        <= 1'b0;
			wb_enable        <= 1'b0;
			branch           <= 1'b0;
			status_write     <= 1'b0;
		end else begin
			// Data fields follow even in a bubble
			pc               <= pc_in;
			immediate        <= imm_bit;
			reg1             <= rf_reg1;
			reg2             <= rf_reg2;
			dest_reg         <= rd;
			signed_immediate <= instruction_in[simm_pos +: signed_immediate_len];
			shift_operand    <= instruction_in[shift_pos +: shift_operand_len];
			execute_command  <= kill ? '0 : cu_execute_command;
			mem_read         <= !kill && cu_mem_read;
			mem_write        <= !kill && cu_mem_write;
			wb_enable        <= !kill && cu_wb_enable;
			branch           <= !kill && cu_branch;
			status_write     <= !kill && cu_status_write;
		end
	end

endmodule

// ==== rtl/if_stage.sv ====
`timescale 1ns/1ps

module if_stage import arm_pkg::*; (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        freeze,
	input  logic                        flush,
	input  logic                        branch_taken,
	input  logic [address_len-1:0]      branch_addr,
	// Instruction memory
	output logic [imem_address_len-1:0] imem_addr,
	input  logic [instruction_len-1:0]  imem_data,
	// IF/ID register
	output logic [address_len-1:0]      pc,
	output logic [instruction_len-1:0]  instruction
);

	logic [address_len-1:0] pc_reg;
	logic [address_len-1:0] pc_next;

	// Sequential fetch address
	assign pc_next = pc_reg + address_len'(4);

	// Byte address to word address
	assign imem_addr = pc_reg[imem_address_len+1:2];

	// Program counter
	// Branch wins over freeze
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_reg <= '0;
		end else if (branch_taken) begin
			pc_reg <= branch_addr;
		end else if (!freeze) begin
			pc_reg <= pc_next;
		end
	end

	// IF/ID register
	// Holds the incremented PC like ARM
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			pc          <= '0;
			instruction <= '0;
		end else if (branch_taken || !freeze) begin
			pc          <= pc_next;
			instruction <= imem_data;
		end
	end

endmodule

// ==== rtl/instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory import arm_pkg::*; (
	input  logic                        clk,
	// Load port, used before the run
	input  logic                        wr_en,
	input  logic [imem_address_len-1:0] wr_addr,
	input  logic [instruction_len-1:0]  wr_data,
	// Fetch port
	input  logic [imem_address_len-1:0] rd_addr,
	output logic [instruction_len-1:0]  rd_data
);

	// One instruction per word
	logic [instruction_len-1:0] mem [imem_words];

	// Single word per cycle
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Fetch is asynchronous so IF/ID sees it the same cycle
	assign rd_data = mem[rd_addr];

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file import arm_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	// Read ports
	input  logic [reg_address_len-1:0] src1,
	input  logic [reg_address_len-1:0] src2,
	output logic [register_len-1:0]    reg1,
	output logic [register_len-1:0]    reg2,
	// Write-back port
	input  logic                       wb_en,
	input  logic [reg_address_len-1:0] wb_address,
	input  logic [register_len-1:0]    wb_data
);

	logic [register_len-1:0] regs [reg_count];

	// Write at the rising edge
	// r15 is the PC, nothing stored for it
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && (wb_address < reg_count)) begin
			regs[wb_address] <= wb_data;
		end
	end

	// Reads see the old value during a write
	assign reg1 = (src1 < reg_count) ? regs[src1] : '0;
	assign reg2 = (src2 < reg_count) ? regs[src2] : '0;

endmodule

// ==== test/arm_decode_model.svh ====
`ifndef ARM_DECODE_MODEL_SVH
`define ARM_DECODE_MODEL_SVH

// Even codes test a flag combination, odd codes its inverse
function automatic logic condition_holds(input logic [3:0] cond, input logic [3:0] flags);
	logic n;
	logic z;
	logic c;
	logic v;
	logic base;
	n = flags[3];
	z = flags[2];
	c = flags[1];
	v = flags[0];
	case (cond[3:1])
		3'd0: base = z;
		3'd1: base = c;
		3'd2: base = n;
		3'd3: base = v;
		3'd4: base = c && !z;
		3'd5: base = (n == v);
		3'd6: base = !z && (n == v);
		default: base = 1'b1;
	endcase
	// Inverse of AL is NV, never runs
	return cond[0] ? !base : base;
endfunction

// ALU command per data processing opcode
function automatic logic [3:0] alu_command(input logic [3:0] opcode);
	logic [3:0] cmd;
	case (opcode)
		op_mov: cmd = 4'b0001;
		op_mvn: cmd = 4'b1001;
		op_add: cmd = 4'b0010;
		op_adc: cmd = 4'b0011;
		op_sub: cmd = 4'b0100;
		op_cmp: cmd = 4'b0100;
		op_sbc: cmd = 4'b0101;
		op_and: cmd = 4'b0110;
		op_tst: cmd = 4'b0110;
		op_orr: cmd = 4'b0111;
		op_eor: cmd = 4'b1000;
		default: cmd = 4'b0000;
	endcase
	return cmd;
endfunction

// Packed as command, mem_read, mem_write, wb_enable, branch, status_write
function automatic logic [8:0] decode_controls(input logic [31:0] word, input logic [3:0] flags);
	logic [3:0] cmd;
	logic       rd_m;
	logic       wr_m;
	logic       wb;
	logic       br;
	logic       sw;
	cmd  = 4'b0000;
	rd_m = 1'b0;
	wr_m = 1'b0;
	wb   = 1'b0;
	br   = 1'b0;
	sw   = 1'b0;
	// Empty slot or failed condition
	if (word == 32'b0 || !condition_holds(word[31:28], flags)) begin
		return 9'b0;
	end
	case (word[27:26])
		2'b00: begin
			cmd = alu_command(word[24:21]);
			sw  = word[20];
			wb  = (word[24:21] != op_cmp) && (word[24:21] != op_tst);
		end
		2'b01: begin
			// Base plus offset
			cmd  = 4'b0010;
			rd_m = word[20];
			wb   = word[20];
			wr_m = !word[20];
		end
		// B needs the I bit, otherwise block transfer
		2'b10: br = word[25];
		default: ;
	endcase
	return {cmd, rd_m, wr_m, wb, br, sw};
endfunction

// Store data comes from Rd
function automatic logic [3:0] second_source(input logic [31:0] word);
	return (word[27:26] == 2'b01 && !word[20]) ? word[15:12] : word[3:0];
endfunction

`endif

// ==== test/tb_arm_frontend.sv ====
`timescale 1ns/1ps

module tb_arm_frontend import arm_pkg::*; ();

	`include "arm_decode_model.svh"

	localparam int reset_cycles    = 16;
	localparam int run_rounds      = 20;
	localparam int watchdog_cycles = imem_words * 4 + 200;

	logic                            clk;
	logic                            rst;
	logic                            imem_wr_en;
	logic [imem_address_len-1:0]     imem_wr_addr;
	logic [instruction_len-1:0]      imem_wr_data;
	logic                            freeze;
	logic                            flush;
	logic                            branch_taken;
	logic [address_len-1:0]          branch_addr;
	logic [3:0]                      status;
	logic                            wb_en;
	logic [reg_address_len-1:0]      wb_address;
	logic [register_len-1:0]         wb_data;
	logic [address_len-1:0]          pc_out;
	logic                            mem_read;
	logic                            mem_write;
	logic                            wb_enable;
	logic                            immediate;
	logic                            branch;
	logic                            status_write;
	logic [execute_command_len-1:0]  execute_command;
	logic [register_len-1:0]         reg1;
	logic [register_len-1:0]         reg2;
	logic [reg_address_len-1:0]      dest_reg;
	logic [signed_immediate_len-1:0] signed_immediate;
	logic [shift_operand_len-1:0]    shift_operand;

	// Mirrors of memory and registers
	logic [instruction_len-1:0] imem_mirror [imem_words];
	logic [register_len-1:0]    reg_mirror [reg_count];

	integer          seed;
	int              error_count = 0;
	int              check_count = 0;
	logic            running = 1'b0;
	logic            applied_freeze = 1'b1;
	logic            applied_flush = 1'b0;
	logic            flushed_before = 1'b0;
	logic            have_last = 1'b0;
	logic [31:0]     last_pc = '0;
	logic            branch_pending = 1'b0;
	logic [31:0]     branch_target = '0;

	arm_frontend UUT (
		.clk              (clk),
		.rst              (rst),
		.imem_wr_en       (imem_wr_en),
		.imem_wr_addr     (imem_wr_addr),
		.imem_wr_data     (imem_wr_data),
		.freeze           (freeze),
		.flush            (flush),
		.branch_taken     (branch_taken),
		.branch_addr      (branch_addr),
		.status           (status),
		.wb_en            (wb_en),
		.wb_address       (wb_address),
		.wb_data          (wb_data),
		.pc               (pc_out),
		.mem_read         (mem_read),
		.mem_write        (mem_write),
		.wb_enable        (wb_enable),
		.immediate        (immediate),
		.branch           (branch),
		.status_write     (status_write),
		.execute_command  (execute_command),
		.reg1             (reg1),
		.reg2             (reg2),
		.dest_reg         (dest_reg),
		.signed_immediate (signed_immediate),
		.shift_operand    (shift_operand)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_field(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			$display("ERROR %s %s expected %h actual %h", test, field, expected, actual);
			error_count++;
		end
	endtask

	// r15 is never stored
	function automatic logic [register_len-1:0] read_mirror(input logic [3:0] index);
		if (index >= reg_count) begin
			return '0;
		end
		return reg_mirror[index];
	endfunction

	function automatic logic [3:0] opcode_choice(input int index);
		case (index)
			0: return op_mov;
			1: return op_mvn;
			2: return op_add;
			3: return op_adc;
			4: return op_sub;
			5: return op_sbc;
			6: return op_and;
			7: return op_orr;
			8: return op_eor;
			9: return op_cmp;
			default: return op_tst;
		endcase
	endfunction

	// Random fields, mode and opcode kept to legal codes
	task automatic make_instruction(output logic [31:0] word);
		word = $random(seed);
		word[27:26] = 2'({$random(seed)} % 3);
		word[24:21] = opcode_choice({$random(seed)} % 11);
	endtask

	// One ID/EX output, identified by its PC
	task automatic check_output();
		logic [31:0]                pc_back;
		logic [instruction_len-1:0] word;
		logic [8:0]                 expected_ctrl;
		logic [4:0]                 actual_flags;
		string                      name;
		actual_flags = {mem_read, mem_write, wb_enable, branch, status_write};
		if (!running) begin
			check_field("reset", "pc_out", '0, pc_out);
		end
		// Flushed slot and the cleared IF/ID slot both leave as zeros
		if (applied_flush || flushed_before) begin
			check_field("flush", "pc_out", '0, pc_out);
		end
		if (pc_out == '0 || applied_freeze) begin
			name = (pc_out != '0) ? "freeze" : (running ? "flush" : "reset");
			check_field(name, "execute_command", '0, 32'(execute_command));
			check_field(name, "control_flags", '0, 32'(actual_flags));
			// Sequence restarts after a flush
			if (pc_out == '0) begin
				have_last = 1'b0;
			end
		end else begin
			name = "free_run";
			if (branch_pending && pc_out == branch_target + 32'd4) begin
				name = "branch";
				branch_pending = 1'b0;
			end else if (have_last) begin
				check_field("sequence", "pc_out", last_pc + 32'd4, pc_out);
			end
			last_pc   = pc_out;
			have_last = 1'b1;
			pc_back = pc_out - 32'd4;
			word = imem_mirror[pc_back[imem_address_len+1:2]];
			expected_ctrl = decode_controls(word, status);
			check_field(name, "execute_command", 32'(expected_ctrl[8:5]),
				32'(execute_command));
			check_field(name, "control_flags", 32'(expected_ctrl[4:0]), 32'(actual_flags));
			check_field(name, "immediate", 32'(word[imm_pos]), 32'(immediate));
			check_field(name, "dest_reg", 32'(word[15:12]), 32'(dest_reg));
			check_field(name, "signed_immediate", 32'(word[23:0]), 32'(signed_immediate));
			check_field(name, "shift_operand", 32'(word[11:0]), 32'(shift_operand));
			check_field("reg_operands", "reg1", read_mirror(word[19:16]), reg1);
			check_field("reg_operands", "reg2", read_mirror(second_source(word)), reg2);
		end
	endtask

	// Outputs settle well before the falling edge
	initial begin
		wait (rst === 1'b0);
		forever begin
			@(negedge clk);
			check_output();
			// Inputs the next rising edge will see
			applied_freeze = freeze;
			flushed_before = applied_flush;
			applied_flush  = flush;
			if (branch_taken) begin
				// Earlier target has to show up before the next branch
				assert (!branch_pending) else begin
					$display("ERROR branch: target %h never reached before the next branch",
						branch_target);
					error_count++;
				end
				branch_pending = 1'b1;
				branch_target  = branch_addr;
			end
		end
	end

	task automatic run_free(input int cycles);
		repeat (cycles) @(posedge clk);
	endtask

	// Target at least 16 words away from the current stream
	task automatic apply_branch();
		logic [imem_address_len-1:0] target_word;
		target_word = last_pc[imem_address_len+1:2]
			+ imem_address_len'(16 + {$random(seed)} % 32);
		@(posedge clk);
		branch_taken <= 1'b1;
		branch_addr  <= address_len'({target_word, 2'b00});
		@(posedge clk);
		branch_taken <= 1'b0;
	endtask

	task automatic apply_freeze(input int cycles);
		@(posedge clk);
		freeze <= 1'b1;
		repeat (cycles) @(posedge clk);
		freeze <= 1'b0;
	endtask

	task automatic apply_flush();
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
	endtask

	initial begin
		logic [31:0] word;
		logic [31:0] value;
		int          pick;
		seed         = 32'h359416ca;
		rst          = 1'b1;
		imem_wr_en   = 1'b0;
		imem_wr_addr = '0;
		imem_wr_data = '0;
		// Held until memory and registers are filled
		freeze       = 1'b1;
		flush        = 1'b0;
		branch_taken = 1'b0;
		branch_addr  = '0;
		wb_en        = 1'b0;
		wb_address   = '0;
		wb_data      = '0;
		status       = 4'($random(seed));
		for (int r = 0; r < reg_count; r++) begin
			reg_mirror[r] = '0;
		end
		// Memory load overlaps reset, register writes follow it
		for (int i = 0; i < imem_words; i++) begin
			@(posedge clk);
			make_instruction(word);
			imem_mirror[i] = word;
			imem_wr_en   <= 1'b1;
			imem_wr_addr <= imem_address_len'(i);
			imem_wr_data <= word;
			if (i == reset_cycles - 1) begin
				rst <= 1'b0;
			end
			if (i >= reset_cycles && i < reset_cycles + 16) begin
				value = $random(seed);
				wb_en      <= 1'b1;
				wb_address <= reg_address_len'(i - reset_cycles);
				wb_data    <= value;
				// Address 15 is dropped by the DUT
				if (i - reset_cycles < reg_count) begin
					reg_mirror[i - reset_cycles] = value;
				end
			end else begin
				wb_en <= 1'b0;
			end
		end
		@(posedge clk);
		imem_wr_en <= 1'b0;
		wb_en      <= 1'b0;
		freeze     <= 1'b0;
		running = 1'b1;
		for (int r = 0; r < run_rounds; r++) begin
			run_free(4 + {$random(seed)} % 5);
			pick = {$random(seed)} % 3;
			case (pick)
				0: apply_branch();
				1: apply_freeze(1 + {$random(seed)} % 4);
				default: apply_flush();
			endcase
		end
		run_free(8);
		@(negedge clk);
		assert (!branch_pending) else begin
			$display("ERROR branch: target %h never reached the decode output", branch_target);
			error_count++;
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Run length bound from memory depth
	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("Test FAILED");
		$finish;
	end

endmodule
